// File: filelist.f
common/isa_pkg.sv
common/uop_pkg.sv
hw/pipe_reg.sv
hw/decode/inst_decoder.sv
hw/decode/id_stage.sv
hw/dual_decode_top.sv
verification/tb_dual_decode.sv

// File: Bender.yml
# two-wide alpha decode front with its testbench
package:
  name: dual_decode

sources:
  # packages first, then the design bottom-up
  - files:
      - common/isa_pkg.sv
      - common/uop_pkg.sv
      - hw/pipe_reg.sv
      - hw/decode/inst_decoder.sv
      - hw/decode/id_stage.sv
      - hw/dual_decode_top.sv

  # simulation only
  - target: simulation
    files:
      - verification/tb_dual_decode.sv

// File: verification/tb_dual_decode.sv
/* two-wide decode front testbench with random bundles, a reference
   decode model, in-order scoreboard, latency and reset checks */
module tb_dual_decode;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int n_bundles      = 2000;
	localparam int timeout_cycles = n_bundles * 4 + 100;   // 25% accept and drain rates

	// expected decode of one slot
	typedef struct packed {
		logic [63:0] opa_value;
		logic [63:0] opb_value;
		logic        opa_is_value;
		logic        opb_is_value;
		logic [4:0]  dest_idx;
		logic [4:0]  alu_func;
		logic [5:0]  op_type;
		logic [1:0]  fu_select;
		logic [7:1]  flags;   // rd, wr, cond, uncond, halt, illegal, valid_inst
	} slot_exp_t;

	logic clock;
	logic rst;
	logic in_valid;
	logic in_ready;
	logic out_valid;
	logic out_ready;
	logic [uop_pkg::issue_width-1:0][31:0] inst;
	logic [uop_pkg::issue_width-1:0]       inst_valid;
	logic [uop_pkg::issue_width-1:0][63:0] npc;
	logic [uop_pkg::issue_width-1:0][63:0] opa_value;
	logic [uop_pkg::issue_width-1:0][63:0] opb_value;
	logic [uop_pkg::issue_width-1:0]       opa_is_value;
	logic [uop_pkg::issue_width-1:0]       opb_is_value;
	logic [uop_pkg::issue_width-1:0][4:0]  dest_idx;
	uop_pkg::alu_func_e [uop_pkg::issue_width-1:0] alu_func;
	logic [uop_pkg::issue_width-1:0][5:0]  op_type;
	uop_pkg::fu_sel_e [uop_pkg::issue_width-1:0]   fu_select;
	logic [uop_pkg::issue_width-1:0]       rd_mem;
	logic [uop_pkg::issue_width-1:0]       wr_mem;
	logic [uop_pkg::issue_width-1:0]       cond_branch;
	logic [uop_pkg::issue_width-1:0]       uncond_branch;
	logic [uop_pkg::issue_width-1:0]       halt;
	logic [uop_pkg::issue_width-1:0]       illegal;
	logic [uop_pkg::issue_width-1:0]       valid_inst;

	uop_pkg::fetch_bundle_t sent_q[$];   // accepted but not yet out
	int  accept_q[$];                    // sample index of accept
	bit  fast_q[$];                      // pipeline was empty at accept
	bit  head_seen;
	int  checks;
	int  errors;
	int  sent;
	int  received;
	int  cycles;
	int  sample;

	dual_decode_top i_dual_decode_top (.*);

	initial begin
		clock = 1'b0;
		forever #5 clock = ~clock;
	end

	task automatic compare(input string name, input logic [63:0] exp, input logic [63:0] act);
		checks++;
		if (exp !== act) begin
			errors++;
			$display("FAIL %s expected %0h actual %0h", name, exp, act);
		end
	endtask

	////////////////////
	// reference model

	// {known, alu op} for a group and function code
	function automatic logic [5:0] alu_lookup(input logic [5:0] op, input logic [6:0] fn);
		case ({op, fn})
			{isa_pkg::inta_grp, isa_pkg::addq_fn}:   return {1'b1, uop_pkg::alu_addq};
			{isa_pkg::inta_grp, isa_pkg::subq_fn}:   return {1'b1, uop_pkg::alu_subq};
			{isa_pkg::inta_grp, isa_pkg::cmpeq_fn}:  return {1'b1, uop_pkg::alu_cmpeq};
			{isa_pkg::inta_grp, isa_pkg::cmpult_fn}: return {1'b1, uop_pkg::alu_cmpult};
			{isa_pkg::inta_grp, isa_pkg::cmpule_fn}: return {1'b1, uop_pkg::alu_cmpule};
			{isa_pkg::inta_grp, isa_pkg::cmplt_fn}:  return {1'b1, uop_pkg::alu_cmplt};
			{isa_pkg::inta_grp, isa_pkg::cmple_fn}:  return {1'b1, uop_pkg::alu_cmple};
			{isa_pkg::intl_grp, isa_pkg::and_fn}:    return {1'b1, uop_pkg::alu_and};
			{isa_pkg::intl_grp, isa_pkg::bic_fn}:    return {1'b1, uop_pkg::alu_bic};
			{isa_pkg::intl_grp, isa_pkg::bis_fn}:    return {1'b1, uop_pkg::alu_bis};
			{isa_pkg::intl_grp, isa_pkg::ornot_fn}:  return {1'b1, uop_pkg::alu_ornot};
			{isa_pkg::intl_grp, isa_pkg::xor_fn}:    return {1'b1, uop_pkg::alu_xor};
			{isa_pkg::intl_grp, isa_pkg::eqv_fn}:    return {1'b1, uop_pkg::alu_eqv};
			{isa_pkg::ints_grp, isa_pkg::srl_fn}:    return {1'b1, uop_pkg::alu_srl};
			{isa_pkg::ints_grp, isa_pkg::sll_fn}:    return {1'b1, uop_pkg::alu_sll};
			{isa_pkg::ints_grp, isa_pkg::sra_fn}:    return {1'b1, uop_pkg::alu_sra};
			{isa_pkg::intm_grp, isa_pkg::mulq_fn}:   return {1'b1, uop_pkg::alu_mulq};
			default:                                 return {1'b0, uop_pkg::alu_addq};
		endcase
	endfunction

	function automatic slot_exp_t model_slot(input logic [31:0] w, input logic v,
	                                         input logic [63:0] pc);
		slot_exp_t  e;
		logic [5:0] op;
		logic [5:0] hit;
		logic [4:0] ra;
		logic [4:0] rc;
		logic       mem_class;
		op = w[isa_pkg::op_lsb +: 6];
		ra = w[isa_pkg::ra_lsb +: 5];
		rc = w[isa_pkg::rc_lsb +: 5];
		mem_class = (op[5:3] == 3'b001) || (op[5:4] == 2'b10);   // 08-0f, 20-2f
		e = '0;   // no-op defaults with register tags and addq
		e.op_type   = op;
		e.opa_value = {59'b0, ra};
		e.opb_value = {59'b0, w[isa_pkg::rb_lsb +: 5]};
		e.dest_idx  = isa_pkg::zero_reg;
		e.alu_func  = uop_pkg::alu_addq;
		if (v) begin
			if (op[5:3] == 3'b000) begin   // pal
				e.flags[3] = (op == isa_pkg::pal_op) && (w[25:0] == isa_pkg::halt_code);
				e.flags[2] = !e.flags[3];
			end else if (op[5:3] == 3'b010) begin   // operate groups
				hit        = alu_lookup(op, w[isa_pkg::func_lsb +: 7]);
				e.alu_func = hit[4:0];
				e.flags[2] = !hit[5];
				e.dest_idx = rc;
				if (w[isa_pkg::lit_flag_bit]) begin
					e.opb_value    = {56'b0, w[isa_pkg::lit_lsb +: 8]};
					e.opb_is_value = 1'b1;
				end
			end else if (op[5:3] == 3'b011) begin
				if (op == isa_pkg::jsr_grp) begin
					e.opa_value    = ~64'h3;   // word-align mask
					e.opa_is_value = 1'b1;
					e.alu_func     = uop_pkg::alu_and;
					e.dest_idx     = ra;
					e.flags[4]     = 1'b1;
				end else
					e.flags[2] = 1'b1;
			end else if (mem_class) begin
				e.opa_value    = {{48{w[15]}}, w[15:0]};
				e.opa_is_value = 1'b1;
				e.dest_idx     = ra;
				if (op == isa_pkg::ldq_op)
					e.flags[7] = 1'b1;
				else if (op == isa_pkg::stq_op) begin
					e.flags[6] = 1'b1;
					e.dest_idx = isa_pkg::zero_reg;
				end else if (op != isa_pkg::lda_op)
					e.flags[2] = 1'b1;
			end else begin   // branch format 30-3f
				e.opa_value    = pc;
				e.opa_is_value = 1'b1;
				e.opb_value    = {{41{w[20]}}, w[20:0], 2'b00};
				e.opb_is_value = 1'b1;
				if (op == isa_pkg::br_op || op == isa_pkg::bsr_op) begin
					e.dest_idx = ra;
					e.flags[4] = 1'b1;
				end else if (op[3])
					e.flags[5] = 1'b1;   // integer conditional
				else
					e.flags[2] = 1'b1;   // fp branch
			end
		end
		e.flags[1] = v && !e.flags[2];
		if (mem_class)
			e.fu_select = uop_pkg::use_memory;
		else if (e.alu_func == uop_pkg::alu_mulq)
			e.fu_select = uop_pkg::use_multiplier;
		else
			e.fu_select = uop_pkg::use_adder;
		return e;
	endfunction

	////////////////////
	// stimulus

	function automatic logic [31:0] random_inst();
		logic [31:0] w;
		int          pick;
		w    = $urandom;   // random fields underneath
		pick = $urandom_range(99);
		if (pick < 30) begin
			case ($urandom_range(9))
				0, 1, 2: w[31:26] = isa_pkg::inta_grp;
				3, 4:    w[31:26] = isa_pkg::intl_grp;
				5, 6:    w[31:26] = isa_pkg::ints_grp;
				7:       w[31:26] = isa_pkg::intm_grp;
				default: w[31:26] = 6'h14 + 6'($urandom_range(3));   // fp groups
			endcase
			case ($urandom_range(19))   // mostly a known code or else random
				0:  w[11:5] = isa_pkg::addq_fn;
				1:  w[11:5] = isa_pkg::subq_fn;
				2:  w[11:5] = isa_pkg::cmpeq_fn;
				3:  w[11:5] = isa_pkg::cmpult_fn;
				4:  w[11:5] = isa_pkg::cmpule_fn;
				5:  w[11:5] = isa_pkg::cmplt_fn;
				6:  w[11:5] = isa_pkg::cmple_fn;
				7:  w[11:5] = isa_pkg::and_fn;
				8:  w[11:5] = isa_pkg::bic_fn;
				9:  w[11:5] = isa_pkg::ornot_fn;
				10: w[11:5] = isa_pkg::xor_fn;
				11: w[11:5] = isa_pkg::eqv_fn;
				12: w[11:5] = isa_pkg::srl_fn;
				13: w[11:5] = isa_pkg::sll_fn;
				14: w[11:5] = isa_pkg::sra_fn;
				15, 16: w[11:5] = isa_pkg::mulq_fn;   // same code as addq and bis
				default: ;
			endcase
		end else if (pick < 50) begin   // memory
			case ($urandom_range(7))
				0, 1:    w[31:26] = isa_pkg::lda_op;
				2, 3:    w[31:26] = isa_pkg::ldq_op;
				4, 5:    w[31:26] = isa_pkg::stq_op;
				default: w[31:26] = 6'h20 + 6'($urandom_range(15));
			endcase
		end else if (pick < 70)
			w[31:26] = 6'h30 + 6'($urandom_range(15));   // branches
		else if (pick < 80)
			w[31:26] = ($urandom_range(3) != 0) ? isa_pkg::jsr_grp : isa_pkg::misc_grp;
		else if (pick < 88) begin
			w[31:26] = isa_pkg::pal_op;
			if ($urandom_range(3) != 0)
				w[25:0] = isa_pkg::halt_code;
		end
		return w;   // the rest stays fully random
	endfunction

	task automatic new_bundle();
		for (int s = 0; s < uop_pkg::issue_width; s++) begin
			inst[s]       = random_inst();
			inst_valid[s] = ($urandom_range(9) != 0);
			npc[s]        = {32'($urandom), 32'($urandom)} & ~64'h3;
		end
	endtask

	////////////////////
	// scoreboard

	task automatic compare_bundle(input uop_pkg::fetch_bundle_t b, input int idx);
		slot_exp_t e;
		string     t;
		for (int s = 0; s < uop_pkg::issue_width; s++) begin
			e = model_slot(b.inst[s], b.valid[s], b.npc[s]);
			t = $sformatf("bundle %0d slot %0d", idx, s);
			compare({t, " opa_value"}, e.opa_value, opa_value[s]);
			compare({t, " opb_value"}, e.opb_value, opb_value[s]);
			compare({t, " opa_is_value"}, e.opa_is_value, opa_is_value[s]);
			compare({t, " opb_is_value"}, e.opb_is_value, opb_is_value[s]);
			compare({t, " dest_idx"}, e.dest_idx, dest_idx[s]);
			compare({t, " alu_func"}, e.alu_func, alu_func[s]);
			compare({t, " op_type"}, e.op_type, op_type[s]);
			compare({t, " fu_select"}, e.fu_select, fu_select[s]);
			compare({t, " flags"}, e.flags, {rd_mem[s], wr_mem[s], cond_branch[s],
				uncond_branch[s], halt[s], illegal[s], valid_inst[s]});
		end
	endtask

	// called at the falling edge while out_valid is high
	task automatic watch_output();
		if (sent_q.size() == 0) begin
			errors++;
			$display("out_valid high with no bundle outstanding at sample %0d", sample);
			return;
		end
		if (!head_seen) begin
			head_seen = 1'b1;
			if (fast_q[0])
				compare($sformatf("bundle %0d latency", received), 2, sample - accept_q[0]);
		end
		if (out_ready) begin
			compare_bundle(sent_q.pop_front(), received);
			void'(accept_q.pop_front());
			void'(fast_q.pop_front());
			head_seen = 1'b0;
			received++;
		end
	endtask

	initial begin : watchdog
		cycles = 0;
		while (cycles < timeout_cycles) begin
			@(posedge clock);
			cycles++;
		end
		$display("timeout: run stopped after %0d cycles, %0d of %0d bundles out",
			cycles, received, n_bundles);
		$display(">>> FAIL");
		$finish;
	end

	initial begin : main
		bit taken;
		void'($urandom(51040));
		rst        = 1'b1;
		in_valid   = 1'b0;
		out_ready  = 1'b0;
		inst       = '0;
		inst_valid = '0;
		npc        = '0;
		checks     = 0;
		errors     = 0;
		sent       = 0;
		received   = 0;
		sample     = 0;
		head_seen  = 1'b0;
		repeat (8) @(posedge clock);
		#1 rst = 1'b0;
		repeat (3) begin   // idle after reset
			@(negedge clock);
			compare("reset out_valid", 0, out_valid);
			compare("reset in_ready", 1, in_ready);
		end
		while (received < n_bundles) begin
			@(negedge clock);
			sample++;
			taken = in_valid && in_ready;
			if (out_valid)
				watch_output();
			if (taken) begin
				fast_q.push_back(sent_q.size() == 0);   // nothing in flight
				accept_q.push_back(sample);
				sent_q.push_back('{inst: inst, valid: inst_valid, npc: npc});
				sent++;
			end
			@(posedge clock);
			#1;
			out_ready = ($urandom_range(9) < 7);
			if (!in_valid || taken) begin   // an offered bundle waits until taken
				in_valid = (sent < n_bundles) && ($urandom_range(9) < 7);
				new_bundle();
			end
		end
		out_ready = 1'b1;
		repeat (5) begin   // nothing extra may appear
			@(negedge clock);
			if (out_valid) begin
				errors++;
				$display("extra bundle on the output after all %0d were received", n_bundles);
			end
		end
		if (sent_q.size() != 0) begin
			errors++;
			$display("%0d bundles left over in the scoreboard", sent_q.size());
		end
		$display("checks %0d, errors %0d, sent %0d, received %0d",
			checks, errors, sent, received);
		if (errors == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

endmodule

// File: hw/dual_decode_top.sv
/* two-wide decode front: fetch register, decode stage,
   dispatch register */
module dual_decode_top (
	input  logic clock,
	input  logic rst,

	// fetch side
	input  logic                                  in_valid,
	output logic                                  in_ready,
	input  logic [uop_pkg::issue_width-1:0][31:0] inst,
	input  logic [uop_pkg::issue_width-1:0]       inst_valid,
	input  logic [uop_pkg::issue_width-1:0][63:0] npc,

	// dispatch side
	output logic                                  out_valid,
	input  logic                                  out_ready,
	output logic [uop_pkg::issue_width-1:0][63:0] opa_value,
	output logic [uop_pkg::issue_width-1:0][63:0] opb_value,
	output logic [uop_pkg::issue_width-1:0]       opa_is_value,
	output logic [uop_pkg::issue_width-1:0]       opb_is_value,
	output logic [uop_pkg::issue_width-1:0][4:0]  dest_idx,
	output uop_pkg::alu_func_e [uop_pkg::issue_width-1:0] alu_func,
	output logic [uop_pkg::issue_width-1:0][5:0]  op_type,
	output uop_pkg::fu_sel_e [uop_pkg::issue_width-1:0]   fu_select,
	output logic [uop_pkg::issue_width-1:0]       rd_mem,
	output logic [uop_pkg::issue_width-1:0]       wr_mem,
	output logic [uop_pkg::issue_width-1:0]       cond_branch,
	output logic [uop_pkg::issue_width-1:0]       uncond_branch,
	output logic [uop_pkg::issue_width-1:0]       halt,
	output logic [uop_pkg::issue_width-1:0]       illegal,
	output logic [uop_pkg::issue_width-1:0]       valid_inst
);

	uop_pkg::fetch_bundle_t  fetch_d, fetch_q;
	uop_pkg::decode_bundle_t dec_d, dec_q;
	logic                    id_valid, id_ready;   // handshake across decode

	assign fetch_d.inst  = inst;
	assign fetch_d.valid = inst_valid;
	assign fetch_d.npc   = npc;

	////////////////////
	// stage 1, fetch register
	pipe_reg #(.payload_t(uop_pkg::fetch_bundle_t)) i_fetch_reg (
		.clock     (clock),
		.rst       (rst),
		.in_valid  (in_valid),
		.in_ready  (in_ready),
		.in_data   (fetch_d),
		.out_valid (id_valid),
		.out_ready (id_ready),
		.out_data  (fetch_q)
	);

	// decode, no state
	id_stage i_id_stage (
		.inst          (fetch_q.inst),
		.valid_in      (fetch_q.valid),
		.npc           (fetch_q.npc),
		.opa_value     (dec_d.opa_value),
		.opb_value     (dec_d.opb_value),
		.opa_is_value  (dec_d.opa_is_value),
		.opb_is_value  (dec_d.opb_is_value),
		.dest_idx      (dec_d.dest_idx),
		.alu_func      (dec_d.alu_func),
		.op_type       (dec_d.op_type),
		.fu_select     (dec_d.fu_select),
		.rd_mem        (dec_d.rd_mem),
		.wr_mem        (dec_d.wr_mem),
		.cond_branch   (dec_d.cond_branch),
		.uncond_branch (dec_d.uncond_branch),
		.halt          (dec_d.halt),
		.illegal       (dec_d.illegal),
		.valid_inst    (dec_d.valid_inst)
	);

	////////////////////
	// stage 2, dispatch register
	pipe_reg #(.payload_t(uop_pkg::decode_bundle_t)) i_dispatch_reg (
		.clock     (clock),
		.rst       (rst),
		.in_valid  (id_valid),
		.in_ready  (id_ready),
		.in_data   (dec_d),
		.out_valid (out_valid),
		.out_ready (out_ready),
		.out_data  (dec_q)
	);

	assign opa_value     = dec_q.opa_value;
	assign opb_value     = dec_q.opb_value;
	assign opa_is_value  = dec_q.opa_is_value;
	assign opb_is_value  = dec_q.opb_is_value;
	assign dest_idx      = dec_q.dest_idx;
	assign alu_func      = dec_q.alu_func;
	assign op_type       = dec_q.op_type;
	assign fu_select     = dec_q.fu_select;
	assign rd_mem        = dec_q.rd_mem;
	assign wr_mem        = dec_q.wr_mem;
	assign cond_branch   = dec_q.cond_branch;
	assign uncond_branch = dec_q.uncond_branch;
	assign halt          = dec_q.halt;
	assign illegal       = dec_q.illegal;
	assign valid_inst    = dec_q.valid_inst;

endmodule

// File: hw/decode/id_stage.sv
/* decode stage: per-slot decoders, immediates,
   operand value/tag muxes, dest index and unit select */
module id_stage (
	input  logic [uop_pkg::issue_width-1:0][31:0] inst,
	input  logic [uop_pkg::issue_width-1:0]       valid_in,
	input  logic [uop_pkg::issue_width-1:0][63:0] npc,

	output logic [uop_pkg::issue_width-1:0][63:0] opa_value,
	output logic [uop_pkg::issue_width-1:0][63:0] opb_value,
	output logic [uop_pkg::issue_width-1:0]       opa_is_value,   // low means reg tag
	output logic [uop_pkg::issue_width-1:0]       opb_is_value,
	output logic [uop_pkg::issue_width-1:0][4:0]  dest_idx,
	output uop_pkg::alu_func_e [uop_pkg::issue_width-1:0] alu_func,
	output logic [uop_pkg::issue_width-1:0][5:0]  op_type,
	output uop_pkg::fu_sel_e [uop_pkg::issue_width-1:0]   fu_select,
	output logic [uop_pkg::issue_width-1:0]       rd_mem,
	output logic [uop_pkg::issue_width-1:0]       wr_mem,
	output logic [uop_pkg::issue_width-1:0]       cond_branch,
	output logic [uop_pkg::issue_width-1:0]       uncond_branch,
	output logic [uop_pkg::issue_width-1:0]       halt,
	output logic [uop_pkg::issue_width-1:0]       illegal,
	output logic [uop_pkg::issue_width-1:0]       valid_inst
);

	for (genvar s = 0; s < uop_pkg::issue_width; s++) begin : g_slot
		uop_pkg::opa_sel_e  opa_sel;
		uop_pkg::opb_sel_e  opb_sel;
		uop_pkg::dest_sel_e dest_sel;
		logic [4:0]         ra, rb, rc;
		logic [63:0]        mem_disp, br_disp, alu_imm;

		// each slot reads its own word
		assign ra = inst[s][isa_pkg::ra_lsb +: 5];
		assign rb = inst[s][isa_pkg::rb_lsb +: 5];
		assign rc = inst[s][isa_pkg::rc_lsb +: 5];

		assign mem_disp = {{48{inst[s][isa_pkg::mem_disp_lsb + 15]}},
		                   inst[s][isa_pkg::mem_disp_lsb +: 16]};
		assign br_disp  = {{41{inst[s][isa_pkg::br_disp_lsb + 20]}},
		                   inst[s][isa_pkg::br_disp_lsb +: 21], 2'b00};   // word offset
		assign alu_imm  = {56'b0, inst[s][isa_pkg::lit_lsb +: 8]};      // zero-ext literal

		assign op_type[s] = inst[s][isa_pkg::op_lsb +: 6];

		inst_decoder i_dec (
			.inst          (inst[s]),
			.valid_in      (valid_in[s]),
			.opa_sel       (opa_sel),
			.opb_sel       (opb_sel),
			.dest_sel      (dest_sel),
			.alu_func      (alu_func[s]),
			.rd_mem        (rd_mem[s]),
			.wr_mem        (wr_mem[s]),
			.cond_branch   (cond_branch[s]),
			.uncond_branch (uncond_branch[s]),
			.halt          (halt[s]),
			.illegal       (illegal[s]),
			.valid_inst    (valid_inst[s])
		);

		////////////////////
		// operand muxes
		always_comb begin
			opa_is_value[s] = 1'b1;
			case (opa_sel)
				uop_pkg::opa_is_mem_disp: opa_value[s] = mem_disp;
				uop_pkg::opa_is_npc:      opa_value[s] = npc[s];
				uop_pkg::opa_is_not3:     opa_value[s] = ~64'h3;
				default: begin            // rega tag
					opa_value[s]    = {59'b0, ra};
					opa_is_value[s] = 1'b0;
				end
			endcase
		end

		always_comb begin
			opb_is_value[s] = 1'b1;
			case (opb_sel)
				uop_pkg::opb_is_alu_imm: opb_value[s] = alu_imm;
				uop_pkg::opb_is_br_disp: opb_value[s] = br_disp;
				default: begin           // regb tag
					opb_value[s]    = {59'b0, rb};
					opb_is_value[s] = 1'b0;
				end
			endcase
		end

		// dest index, r31 when nothing is written
		always_comb begin
			case (dest_sel)
				uop_pkg::dest_is_rega: dest_idx[s] = ra;
				uop_pkg::dest_is_regc: dest_idx[s] = rc;
				default:               dest_idx[s] = isa_pkg::zero_reg;
			endcase
		end

		// unit select by opcode class, mulq to the multiplier
		always_comb begin
			case ({op_type[s][5:3], 3'b000})
				6'h08, 6'h20, 6'h28: fu_select[s] = uop_pkg::use_memory;
				default:
					fu_select[s] = (alu_func[s] == uop_pkg::alu_mulq) ? uop_pkg::use_multiplier
					                                                  : uop_pkg::use_adder;
			endcase
		end
	end

endmodule

// File: hw/decode/inst_decoder.sv
/* combinational decode of one alpha word into
   operand/dest/alu selects and control flags */
module inst_decoder (
	input  logic [31:0]        inst,
	input  logic               valid_in,      // low gives a no-op
	output uop_pkg::opa_sel_e  opa_sel,
	output uop_pkg::opb_sel_e  opb_sel,
	output uop_pkg::dest_sel_e dest_sel,
	output uop_pkg::alu_func_e alu_func,
	output logic               rd_mem,
	output logic               wr_mem,
	output logic               cond_branch,
	output logic               uncond_branch,
	output logic               halt,
	output logic               illegal,
	output logic               valid_inst     // for instruction counts
);

	logic [5:0] op;
	logic [6:0] func;

	assign op         = inst[isa_pkg::op_lsb +: 6];
	assign func       = inst[isa_pkg::func_lsb +: 7];
	assign valid_inst = valid_in & ~illegal;

	always_comb begin
		// no-op defaults
		opa_sel       = uop_pkg::opa_is_rega;
		opb_sel       = uop_pkg::opb_is_regb;
		dest_sel      = uop_pkg::dest_none;
		alu_func      = uop_pkg::alu_addq;
		rd_mem        = 1'b0;
		wr_mem        = 1'b0;
		cond_branch   = 1'b0;
		uncond_branch = 1'b0;
		halt          = 1'b0;
		illegal       = 1'b0;
		if (valid_in) begin
			case ({op[5:3], 3'b000})   // opcode class
				6'h00: begin
					if (op == isa_pkg::pal_op && inst[25:0] == isa_pkg::halt_code)
						halt = 1'b1;
					else
						illegal = 1'b1;   // other pal calls too
				end
				6'h10: begin   // operate format
					opb_sel  = inst[isa_pkg::lit_flag_bit] ? uop_pkg::opb_is_alu_imm
					                                       : uop_pkg::opb_is_regb;
					dest_sel = uop_pkg::dest_is_regc;
					case (op)
						isa_pkg::inta_grp:
							case (func)
								isa_pkg::addq_fn:   alu_func = uop_pkg::alu_addq;
								isa_pkg::subq_fn:   alu_func = uop_pkg::alu_subq;
								isa_pkg::cmpeq_fn:  alu_func = uop_pkg::alu_cmpeq;
								isa_pkg::cmpult_fn: alu_func = uop_pkg::alu_cmpult;
								isa_pkg::cmpule_fn: alu_func = uop_pkg::alu_cmpule;
								isa_pkg::cmplt_fn:  alu_func = uop_pkg::alu_cmplt;
								isa_pkg::cmple_fn:  alu_func = uop_pkg::alu_cmple;
								default:            illegal  = 1'b1;
							endcase
						isa_pkg::intl_grp:
							case (func)
								isa_pkg::and_fn:   alu_func = uop_pkg::alu_and;
								isa_pkg::bic_fn:   alu_func = uop_pkg::alu_bic;
								isa_pkg::bis_fn:   alu_func = uop_pkg::alu_bis;
								isa_pkg::ornot_fn: alu_func = uop_pkg::alu_ornot;
								isa_pkg::xor_fn:   alu_func = uop_pkg::alu_xor;
								isa_pkg::eqv_fn:   alu_func = uop_pkg::alu_eqv;
								default:           illegal  = 1'b1;
							endcase
						isa_pkg::ints_grp:
							case (func)
								isa_pkg::srl_fn: alu_func = uop_pkg::alu_srl;
								isa_pkg::sll_fn: alu_func = uop_pkg::alu_sll;
								isa_pkg::sra_fn: alu_func = uop_pkg::alu_sra;
								default:         illegal  = 1'b1;
							endcase
						isa_pkg::intm_grp:
							if (func == isa_pkg::mulq_fn)
								alu_func = uop_pkg::alu_mulq;
							else
								illegal = 1'b1;
						default: illegal = 1'b1;   // itfp, fltv, flti, fltl
					endcase
				end
				6'h18: begin
					if (op == isa_pkg::jsr_grp) begin
						// all four jump kinds behave alike
						opa_sel       = uop_pkg::opa_is_not3;
						alu_func      = uop_pkg::alu_and;   // mask low 2 bits of rb
						dest_sel      = uop_pkg::dest_is_rega;
						uncond_branch = 1'b1;
					end else
						illegal = 1'b1;   // misc, ftpi, holes
				end
				6'h08, 6'h20, 6'h28: begin   // memory format, ea = disp + rb
					opa_sel  = uop_pkg::opa_is_mem_disp;
					dest_sel = uop_pkg::dest_is_rega;
					case (op)
						isa_pkg::lda_op: ;
						isa_pkg::ldq_op: rd_mem = 1'b1;
						isa_pkg::stq_op: begin
							wr_mem   = 1'b1;
							dest_sel = uop_pkg::dest_none;   // nothing written back
						end
						default: illegal = 1'b1;
					endcase
				end
				default: begin   // 6'h30 and 6'h38, branch format
					opa_sel = uop_pkg::opa_is_npc;
					opb_sel = uop_pkg::opb_is_br_disp;
					case (op)
						isa_pkg::br_op, isa_pkg::bsr_op: begin
							dest_sel      = uop_pkg::dest_is_rega;   // return address
							uncond_branch = 1'b1;
						end
						isa_pkg::fbeq_op, isa_pkg::fblt_op, isa_pkg::fble_op,
						isa_pkg::fbne_op, isa_pkg::fbge_op, isa_pkg::fbgt_op:
							illegal = 1'b1;
						isa_pkg::blbc_op, isa_pkg::beq_op, isa_pkg::blt_op,
						isa_pkg::ble_op, isa_pkg::blbs_op, isa_pkg::bne_op,
						isa_pkg::bge_op, isa_pkg::bgt_op:
							cond_branch = 1'b1;
						default: ;
					endcase
				end
			endcase
		end
	end

	// a halt is a legal instruction
	a_halt_not_illegal: assert final (!(halt && illegal));

endmodule

// File: hw/pipe_reg.sv
/* one-entry valid/ready register slice, generic payload */
module pipe_reg #(
	parameter type payload_t = logic [31:0]
) (
	input  logic     clock,
	input  logic     rst,
	input  logic     in_valid,
	output logic     in_ready,
	input  payload_t in_data,
	output logic     out_valid,
	input  logic     out_ready,
	output payload_t out_data
);

	logic load;

	// take new data when empty or when the held entry leaves now
	assign in_ready = ~out_valid | out_ready;
	assign load     = in_valid & in_ready;

	always_ff @(posedge clock) begin
		if (rst)
			out_valid <= 1'b0;
		else if (in_ready)
			out_valid <= in_valid;   // refill or drain
	end

	always_ff @(posedge clock) begin
		if (load)
			out_data <= in_data;     // payload only
	end

	////////////////////
	// checks
	a_hold_stable: assert property (@(posedge clock) disable iff (rst)
		out_valid && !out_ready |=> out_valid && $stable(out_data));

	a_empty_after_rst: assert property (@(posedge clock) rst |=> !out_valid);

endmodule

// File: common/uop_pkg.sv
/* decoded control encodings, issue width,
   fetch and decode bundle structs */
package uop_pkg;

	localparam int issue_width = 2;   // slots per bundle

	////////////////////
	// alu ops
	typedef enum logic [4:0] {
		alu_addq,
		alu_subq,
		alu_and,
		alu_bic,
		alu_bis,
		alu_ornot,
		alu_xor,
		alu_eqv,
		alu_srl,
		alu_sll,
		alu_sra,
		alu_mulq,
		alu_cmpeq,
		alu_cmplt,
		alu_cmple,
		alu_cmpult,
		alu_cmpule
	} alu_func_e;

	// operand sources
	typedef enum logic [1:0] {
		opa_is_rega,
		opa_is_mem_disp,
		opa_is_npc,
		opa_is_not3       // word-align mask for jumps
	} opa_sel_e;

	typedef enum logic [1:0] {
		opb_is_regb,
		opb_is_alu_imm,
		opb_is_br_disp
	} opb_sel_e;

	typedef enum logic [1:0] {dest_none, dest_is_rega, dest_is_regc} dest_sel_e;

	typedef enum logic [1:0] {use_adder, use_multiplier, use_memory} fu_sel_e;

	////////////////////
	// bundles, fields indexed by slot
	typedef struct packed {
		logic [issue_width-1:0][31:0] inst;
		logic [issue_width-1:0]       valid;
		logic [issue_width-1:0][63:0] npc;
	} fetch_bundle_t;

	typedef struct packed {
		logic      [issue_width-1:0][63:0] opa_value;   // value or tag in low bits
		logic      [issue_width-1:0][63:0] opb_value;
		logic      [issue_width-1:0]       opa_is_value;
		logic      [issue_width-1:0]       opb_is_value;
		logic      [issue_width-1:0][4:0]  dest_idx;
		alu_func_e [issue_width-1:0]       alu_func;
		logic      [issue_width-1:0][5:0]  op_type;
		fu_sel_e   [issue_width-1:0]       fu_select;
		logic      [issue_width-1:0]       rd_mem;
		logic      [issue_width-1:0]       wr_mem;
		logic      [issue_width-1:0]       cond_branch;
		logic      [issue_width-1:0]       uncond_branch;
		logic      [issue_width-1:0]       halt;
		logic      [issue_width-1:0]       illegal;
		logic      [issue_width-1:0]       valid_inst;
	} decode_bundle_t;

endpackage

// File: common/isa_pkg.sv
/* alpha integer subset: opcodes, group and function codes,
   pal halt code, zero register and instruction field positions */
package isa_pkg;

	////////////////////
	// primary opcodes
	localparam logic [5:0] pal_op  = 6'h00;
	localparam logic [5:0] lda_op  = 6'h08;
	localparam logic [5:0] ldq_op  = 6'h29;
	localparam logic [5:0] stq_op  = 6'h2d;
	localparam logic [5:0] br_op   = 6'h30;   // unconditional
	localparam logic [5:0] bsr_op  = 6'h34;   // unconditional, links ra

	// fp branches, no fp unit here
	localparam logic [5:0] fbeq_op = 6'h31;
	localparam logic [5:0] fblt_op = 6'h32;
	localparam logic [5:0] fble_op = 6'h33;
	localparam logic [5:0] fbne_op = 6'h35;
	localparam logic [5:0] fbge_op = 6'h36;
	localparam logic [5:0] fbgt_op = 6'h37;

	// integer conditional branches
	localparam logic [5:0] blbc_op = 6'h38;
	localparam logic [5:0] beq_op  = 6'h39;
	localparam logic [5:0] blt_op  = 6'h3a;
	localparam logic [5:0] ble_op  = 6'h3b;
	localparam logic [5:0] blbs_op = 6'h3c;
	localparam logic [5:0] bne_op  = 6'h3d;
	localparam logic [5:0] bge_op  = 6'h3e;
	localparam logic [5:0] bgt_op  = 6'h3f;

	////////////////////
	// operate groups, func field picks the op
	localparam logic [5:0] inta_grp = 6'h10;   // arith + compares
	localparam logic [5:0] intl_grp = 6'h11;   // logical
	localparam logic [5:0] ints_grp = 6'h12;   // shifts
	localparam logic [5:0] intm_grp = 6'h13;   // multiply
	localparam logic [5:0] itfp_grp = 6'h14;
	localparam logic [5:0] fltv_grp = 6'h15;
	localparam logic [5:0] flti_grp = 6'h16;
	localparam logic [5:0] fltl_grp = 6'h17;
	localparam logic [5:0] misc_grp = 6'h18;
	localparam logic [5:0] jsr_grp  = 6'h1a;   // jmp/jsr/ret/jsr_co
	localparam logic [5:0] ftpi_grp = 6'h1c;

	// function codes, inst[11:5]
	localparam logic [6:0] addq_fn   = 7'h20;
	localparam logic [6:0] subq_fn   = 7'h29;
	localparam logic [6:0] cmpeq_fn  = 7'h2d;
	localparam logic [6:0] cmpult_fn = 7'h1d;
	localparam logic [6:0] cmpule_fn = 7'h3d;
	localparam logic [6:0] cmplt_fn  = 7'h4d;
	localparam logic [6:0] cmple_fn  = 7'h6d;
	localparam logic [6:0] and_fn    = 7'h00;
	localparam logic [6:0] bic_fn    = 7'h08;
	localparam logic [6:0] bis_fn    = 7'h20;
	localparam logic [6:0] ornot_fn  = 7'h28;
	localparam logic [6:0] xor_fn    = 7'h40;
	localparam logic [6:0] eqv_fn    = 7'h48;
	localparam logic [6:0] srl_fn    = 7'h34;
	localparam logic [6:0] sll_fn    = 7'h39;
	localparam logic [6:0] sra_fn    = 7'h3c;
	localparam logic [6:0] mulq_fn   = 7'h20;

	localparam logic [25:0] halt_code = 26'h0555;   // call_pal halt
	localparam logic [4:0]  zero_reg  = 5'd31;

	////////////////////
	// field lsbs
	localparam int op_lsb       = 26;   // 6 bits
	localparam int ra_lsb       = 21;   // 5 bits
	localparam int rb_lsb       = 16;
	localparam int rc_lsb       = 0;
	localparam int lit_flag_bit = 12;
	localparam int lit_lsb      = 13;   // 8 bits
	localparam int func_lsb     = 5;    // 7 bits
	localparam int mem_disp_lsb = 0;    // 16 bits
	localparam int br_disp_lsb  = 0;    // 21 bits

endpackage
